/* include/cpc_consts.svh */
`ifndef CPC_CONSTS_SVH
`define CPC_CONSTS_SVH

// --------------------
// ROM download
// --------------------
`define ROM_INDEX_LIMIT   5'd4            // Index [4:0] below this is a ROM file
`define PAGE_OS6128       9'h000          // Lower ROM
`define PAGE_BASIC        9'h100          // Upper ROM slot 0
`define PAGE_AMSDOS       9'h107          // Upper ROM slot 7
`define PAGE_MF2          9'h0ff          // Multiface ROM, not in the upper map

// --------------------
// Multiface Two
// --------------------
`define MF2_NMI_VECTOR    16'h0066        // Z80 NMI entry
`define MF2_HIDE_ADDR     16'h0065        // Fetch here hides the cartridge
`define MF2_CTRL_PORT     14'b11111110111010  // fee8 enable, feea disable
`define MF2_RAM_WORDS     8192

// Shadow copies of the CPC hardware registers
`define MF2_ST_PEN_SEL    13'h1fcf
`define MF2_ST_BORDER     13'h1fdf
`define MF2_ST_MODE       13'h1fef
`define MF2_ST_BANK       13'h1fff
`define MF2_ST_CRTC_SEL   13'h1cff
`define MF2_ST_PPI        13'h17ff
`define MF2_ST_UPPER_ROM  13'h1aac
`define MF2_ROW_PEN       9'h1f9          // 16 pen colours
`define MF2_ROW_CRTC      9'h1db          // 16 CRTC registers

`endif

/* design/cpc_pkg.sv */
package cpc_pkg;

    // Boot memory address, built as page/offset, read back as ROM slot
    typedef union packed {
        struct packed {
            logic [8:0]  page;
            logic [13:0] offset;
        } pg;
        struct packed {
            logic        upper;   // Upper ROM bank
            logic [7:0]  slot;
            logic [13:0] offset;
        } rom;
    } boot_addr_u;

    // MF2 RAM address, flat or as a 16-entry row
    typedef union packed {
        logic [12:0] flat;
        struct packed {
            logic [8:0] row;
            logic [3:0] idx;
        } row;
    } mf2_store_addr_u;

endpackage

/* design/rom_loader.sv */
`timescale 1ns/1ps
`include "cpc_consts.svh"

module rom_loader import cpc_pkg::*; (
    input  logic         clk_48,
    input  logic         RESET,
    input  logic         ioctl_download,
    input  logic         ioctl_wr,
    input  logic [24:0]  ioctl_addr,
    input  logic [7:0]   ioctl_dout,
    input  logic [7:0]   ioctl_index,
    output logic         boot_wr,
    output boot_addr_u   boot_a,
    output logic [7:0]   boot_dout,
    output logic [255:0] rom_map,
    output logic         core_reset,
    output logic         rom_loaded
);

    logic       download_q;    // Previous ioctl_download
    logic       rom_download;
    logic       chunk_hit;     // Chunk maps to a known ROM
    logic [8:0] chunk_page;

    assign rom_download = ioctl_download && (ioctl_index[4:0] < `ROM_INDEX_LIMIT);

    // --------------------
    // 16 KB chunk to boot page
    // --------------------
    always_comb begin
        chunk_hit  = 1'b1;
        chunk_page = `PAGE_OS6128;
        case (ioctl_addr[24:14])
            11'd0:   chunk_page = `PAGE_OS6128;
            11'd1:   chunk_page = `PAGE_BASIC;
            11'd2:   chunk_page = `PAGE_AMSDOS;
            11'd3:   chunk_page = `PAGE_MF2;
            default: chunk_hit = 1'b0;  // Past the last ROM so dropped
        endcase
    end

    // Address and data of the boot write
    always_ff @(posedge clk_48) begin
        if (rom_download && ioctl_wr) begin
            boot_a.pg.page   <= chunk_page;
            boot_a.pg.offset <= ioctl_addr[13:0];
            boot_dout        <= ioctl_dout;
        end
    end

    // --------------------
    // Strobe, ROM map, core reset
    // --------------------
    always_ff @(posedge clk_48) begin
        if (RESET) begin
            download_q <= 1'b0;
            boot_wr    <= 1'b0;
            rom_map    <= '0;
            core_reset <= 1'b1;     // Hold core until a file arrives
            rom_loaded <= 1'b0;
        end else begin
            download_q <= ioctl_download;
            boot_wr    <= rom_download && ioctl_wr && chunk_hit;
            if (boot_wr && boot_a.rom.upper)
                rom_map[boot_a.rom.slot] <= 1'b1;  // Mark slot present
            if (ioctl_download && !download_q)
                core_reset <= 1'b0;   // Start of download
            if (!ioctl_download && download_q)
                rom_loaded <= 1'b1;   // End of download
        end
    end

    // Strobe comes only from a byte taken while the download ran
    a_boot_in_download: assert property (@(posedge clk_48) disable iff (RESET)
        boot_wr |-> download_q);

endmodule

/* design/mf2_trap.sv */
`timescale 1ns/1ps
`include "cpc_consts.svh"

module mf2_trap (
    input  logic        clk_48,
    input  logic        RESET,
    input  logic [15:0] cpu_addr,
    input  logic        m1,
    input  logic        iorq,
    input  logic        wr,
    input  logic        key_nmi,
    output logic        mf2_nmi,
    output logic        mf2_en,
    output logic        mf2_rom_en,
    output logic        mf2_ram_en,
    output logic        io_write_strobe
);

    logic key_nmi_q;   // Edge detect history
    logic m1_q;
    logic io_wr_q;
    logic io_wr;
    logic hidden;      // Port cannot page in while set
    logic key_rise;
    logic m1_rise;

    assign io_wr           = iorq & wr;
    assign io_write_strobe = io_wr & ~io_wr_q;  // First cycle of an OUT
    assign key_rise        = key_nmi & ~key_nmi_q;
    assign m1_rise         = m1 & ~m1_q;

    // --------------------
    // Trap and paging state
    // --------------------
    always_ff @(posedge clk_48) begin
        if (RESET) begin
            key_nmi_q <= 1'b0;
            m1_q      <= 1'b0;
            io_wr_q   <= 1'b0;
            mf2_nmi   <= 1'b0;
            mf2_en    <= 1'b0;
            hidden    <= 1'b0;
        end else begin
            key_nmi_q <= key_nmi;
            m1_q      <= m1;
            io_wr_q   <= io_wr;
            if (key_rise && !mf2_en)
                mf2_nmi <= 1'b1;      // Button only counts when paged out
            if (mf2_nmi && m1_rise && cpu_addr == `MF2_NMI_VECTOR) begin
                mf2_en  <= 1'b1;      // Vector fetch pages the cartridge in
                hidden  <= 1'b0;
                mf2_nmi <= 1'b0;
            end
            if (mf2_en && m1_rise && cpu_addr == `MF2_HIDE_ADDR)
                hidden <= 1'b1;
            if (io_write_strobe && cpu_addr[15:2] == `MF2_CTRL_PORT)
                mf2_en <= ~cpu_addr[1] & ~hidden;   // fee8 on and feea off
        end
    end

    // ROM in 0000-1fff and RAM in 2000-3fff
    assign mf2_rom_en = mf2_en && (cpu_addr[15:13] == 3'b000);
    assign mf2_ram_en = mf2_en && (cpu_addr[15:13] == 3'b001);

    // Opcode fetch and OUT never share a cycle
    a_fetch_not_out: assert property (@(posedge clk_48) disable iff (RESET)
        !(m1 && io_wr));

endmodule

/* design/mf2_shadow.sv */
`timescale 1ns/1ps
`include "cpc_consts.svh"

module mf2_shadow import cpc_pkg::*; (
    input  logic        clk_48,
    input  logic        RESET,
    input  logic [15:0] cpu_addr,
    input  logic [7:0]  cpu_dout,
    input  logic        mem_rd,
    input  logic        mem_wr,
    input  logic        mf2_ram_en,
    input  logic        io_write_strobe,
    output logic [7:0]  mf2_dout
);

    mf2_store_addr_u store_addr;      // Zero means no store
    logic [4:0]      pen_index;       // Last gate array pen select
    logic [3:0]      crtc_reg;        // Last CRTC register select
    logic            store_hit;
    logic            cpu_ram_wr;
    logic [12:0]     ram_a;
    logic [7:0]      ram_in;
    logic            ram_we;
    logic [7:0]      ram_out;
    logic [7:0]      ram [`MF2_RAM_WORDS];

    // --------------------
    // Port to shadow address
    // --------------------
    always_comb begin
        store_addr.flat = '0;
        case (cpu_addr[15:8])
            8'h7f: begin                        // Gate array, function in [7:6]
                case (cpu_dout[7:6])
                    2'b00: store_addr.flat = `MF2_ST_PEN_SEL;
                    2'b01: begin
                        if (pen_index[4]) begin
                            store_addr.flat = `MF2_ST_BORDER;
                        end else begin
                            store_addr.row.row = `MF2_ROW_PEN;
                            store_addr.row.idx = pen_index[3:0];
                        end
                    end
                    2'b10: store_addr.flat = `MF2_ST_MODE;
                    2'b11: store_addr.flat = `MF2_ST_BANK;
                endcase
            end
            8'hbc: store_addr.flat = `MF2_ST_CRTC_SEL;
            8'hbd: begin                        // CRTC data
                store_addr.row.row = `MF2_ROW_CRTC;
                store_addr.row.idx = crtc_reg;
            end
            8'hf7: store_addr.flat = `MF2_ST_PPI;      // 8255 control
            8'hdf: store_addr.flat = `MF2_ST_UPPER_ROM;
            default: store_addr.flat = '0;      // fee8 lands here too
        endcase
    end

    assign store_hit  = io_write_strobe && (store_addr.flat != '0);
    assign cpu_ram_wr = mem_wr && mf2_ram_en;

    // Selects and write enable
    always_ff @(posedge clk_48) begin
        if (RESET) begin
            pen_index <= '0;
            crtc_reg  <= '0;
            ram_we    <= 1'b0;
        end else begin
            if (store_hit && cpu_addr[15:8] == 8'h7f && cpu_dout[7:6] == 2'b00)
                pen_index <= cpu_dout[4:0];
            if (store_hit && cpu_addr[15:8] == 8'hbc)
                crtc_reg <= cpu_dout[3:0];
            ram_we <= store_hit || cpu_ram_wr;
        end
    end

    // --------------------
    // 8 KB RAM
    // --------------------
    always_ff @(posedge clk_48) begin
        ram_a  <= store_hit ? store_addr.flat : cpu_addr[12:0];  // Store wins
        ram_in <= cpu_dout;
    end

    always_ff @(posedge clk_48) begin
        if (ram_we) begin
            ram[ram_a] <= ram_in;
            ram_out    <= ram_in;     // Write-through
        end else begin
            ram_out <= ram[ram_a];
        end
    end

    assign mf2_dout = (mf2_ram_en && mem_rd) ? ram_out : 8'hff;  // Open bus ff

    // OUT cycle and memory write from the Z80 never overlap
    a_store_vs_cpu: assert property (@(posedge clk_48) disable iff (RESET)
        store_hit |-> !cpu_ram_wr);

endmodule

/* design/cpc_mf2_top.sv */
`timescale 1ns/1ps

module cpc_mf2_top import cpc_pkg::*; (
    input  logic         clk_48,
    input  logic         RESET,

    // Download port
    input  logic         ioctl_download,
    input  logic         ioctl_wr,
    input  logic [24:0]  ioctl_addr,
    input  logic [7:0]   ioctl_dout,
    input  logic [7:0]   ioctl_index,

    // Boot memory writes
    output logic         boot_wr,
    output boot_addr_u   boot_a,
    output logic [7:0]   boot_dout,
    output logic [255:0] rom_map,
    output logic         core_reset,
    output logic         rom_loaded,

    // Z80 bus
    input  logic [15:0]  cpu_addr,
    input  logic [7:0]   cpu_dout,
    input  logic         m1,
    input  logic         iorq,
    input  logic         wr,
    input  logic         mem_rd,
    input  logic         mem_wr,
    input  logic         key_nmi,

    // Multiface
    output logic         mf2_nmi,
    output logic         mf2_en,
    output logic         mf2_rom_en,
    output logic         mf2_ram_en,
    output logic [7:0]   mf2_dout
);

    logic io_write_strobe;   // Trap to shadow

    rom_loader u_rom_loader (
        .clk_48(clk_48), .RESET(RESET),
        .ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr),
        .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_index(ioctl_index),
        .boot_wr(boot_wr), .boot_a(boot_a), .boot_dout(boot_dout),
        .rom_map(rom_map), .core_reset(core_reset), .rom_loaded(rom_loaded)
    );

    mf2_trap u_mf2_trap (
        .clk_48(clk_48), .RESET(RESET),
        .cpu_addr(cpu_addr), .m1(m1), .iorq(iorq), .wr(wr), .key_nmi(key_nmi),
        .mf2_nmi(mf2_nmi), .mf2_en(mf2_en),
        .mf2_rom_en(mf2_rom_en), .mf2_ram_en(mf2_ram_en),
        .io_write_strobe(io_write_strobe)
    );

    mf2_shadow u_mf2_shadow (
        .clk_48(clk_48), .RESET(RESET),
        .cpu_addr(cpu_addr), .cpu_dout(cpu_dout),
        .mem_rd(mem_rd), .mem_wr(mem_wr),
        .mf2_ram_en(mf2_ram_en), .io_write_strobe(io_write_strobe),
        .mf2_dout(mf2_dout)
    );

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_48,
    output logic RESET
);

    // Free-running clock, first rising edge half a period in
    initial begin
        clk_48 = 1'b0;
        forever #(PERIOD_NS / 2) clk_48 = ~clk_48;
    end

    initial begin
        RESET <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_48);
        RESET <= 1'b0;                  // Released on a rising edge
    end

endmodule

/* tests/tb_top.sv */
`timescale 1ns/1ps

module tb_top import cpc_pkg::*; ();

    localparam int CLK_PERIOD_NS = 40;
    localparam int WAIT_LIMIT    = 8;                           // Cycles for any awaited flag
    localparam int RUN_CYCLES    = 2 + 90 + 20 + 45 + 90 + 60;  // Reset plus each test
    localparam int WATCHDOG_NS   = 2 * RUN_CYCLES * CLK_PERIOD_NS;

    logic         clk_48, RESET;
    logic         ioctl_download, ioctl_wr;
    logic [24:0]  ioctl_addr;
    logic [7:0]   ioctl_dout, ioctl_index;
    logic         boot_wr;
    boot_addr_u   boot_a;
    logic [7:0]   boot_dout;
    logic [255:0] rom_map;
    logic         core_reset, rom_loaded;
    logic [15:0]  cpu_addr;
    logic [7:0]   cpu_dout;
    logic         m1, iorq, wr, mem_rd, mem_wr, key_nmi;   // Z80 side driven here
    logic         mf2_nmi, mf2_en, mf2_rom_en, mf2_ram_en;
    logic [7:0]   mf2_dout;
    integer       seed;

    tb_clock #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(2)) u_clock (
        .clk_48(clk_48), .RESET(RESET)
    );
    cpc_mf2_top dut (.*);

    // --------------------
    // Checking helpers
    // --------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else fail_run($sformatf("MISMATCH %s: got %0h, expected %0h", name, got, exp));
    endtask

    function automatic logic read_flag(input string name);
        if (name == "core_reset")
            return core_reset;
        else if (name == "rom_loaded")
            return rom_loaded;
        else if (name == "boot_wr")
            return boot_wr;
        else if (name == "mf2_nmi")
            return mf2_nmi;
        return mf2_en;
    endfunction

    // Poll at falling edges up to WAIT_LIMIT cycles
    task automatic wait_flag(input string name, input logic level);
        int n;
        n = 0;
        @(negedge clk_48);
        while (read_flag(name) !== level && n < WAIT_LIMIT) begin
            n++;
            @(negedge clk_48);
        end
        if (read_flag(name) !== level)
            fail_run($sformatf("Timed out waiting for %s to become %0b", name, level));
    endtask

    // Boot page for each 16 KB download chunk
    function automatic logic [8:0] page_for_chunk(input int chunk);
        case (chunk)
            0:       return 9'h000;     // OS
            1:       return 9'h100;     // BASIC in upper slot 0
            2:       return 9'h107;     // AMSDOS in upper slot 7
            default: return 9'h0ff;     // Multiface
        endcase
    endfunction

    // --------------------
    // Bus cycles
    // --------------------
    task automatic rom_byte(input logic [24:0] addr, input logic [7:0] data);
        @(posedge clk_48);
        ioctl_addr <= addr;
        ioctl_dout <= data;
        ioctl_wr   <= 1'b1;
        @(posedge clk_48);
        ioctl_wr   <= 1'b0;               // One byte per high cycle
    endtask

    task automatic fetch_m1(input logic [15:0] addr);
        @(posedge clk_48);
        cpu_addr <= addr;
        m1       <= 1'b1;
        repeat (3) @(posedge clk_48);
        m1       <= 1'b0;
    endtask

    // OUT held three cycles plus one idle cycle
    task automatic io_write(input logic [15:0] port, input logic [7:0] data);
        @(posedge clk_48);
        cpu_addr <= port;
        cpu_dout <= data;
        iorq     <= 1'b1;
        wr       <= 1'b1;
        repeat (3) @(posedge clk_48);
        iorq     <= 1'b0;
        wr       <= 1'b0;
        @(posedge clk_48);
    endtask

    // Read data is sampled after the two registered RAM stages
    task automatic mem_cycle(input logic [15:0] addr, input logic write, input logic [7:0] data,
                             output logic [7:0] rdata);
        @(posedge clk_48);
        cpu_addr <= addr;
        cpu_dout <= data;
        mem_wr   <= write;
        mem_rd   <= !write;
        repeat (3) @(posedge clk_48);
        @(negedge clk_48);
        rdata = mf2_dout;
        @(posedge clk_48);
        mem_wr <= 1'b0;
        mem_rd <= 1'b0;
    endtask

    task automatic check_window(input logic [15:0] addr, input logic rom_exp, input logic ram_exp);
        @(posedge clk_48);
        cpu_addr <= addr;
        @(negedge clk_48);
        expect_eq("mf2_rom_en", 32'(mf2_rom_en), 32'(rom_exp));
        expect_eq("mf2_ram_en", 32'(mf2_ram_en), 32'(ram_exp));
    endtask

    task automatic press_nmi();
        @(posedge clk_48);
        key_nmi <= 1'b1;
        wait_flag("mf2_nmi", 1'b1);
        @(posedge clk_48);
        key_nmi <= 1'b0;
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_rom_load();
        logic [255:0] map_exp;
        logic [8:0]   page;
        logic [13:0]  offset;
        logic [7:0]   data;
        integer       rnd;
        map_exp = 256'h81;                 // BASIC in slot 0 and AMSDOS in slot 7
        @(posedge clk_48);
        ioctl_index    <= 8'h00;
        ioctl_download <= 1'b1;
        wait_flag("core_reset", 1'b0);      // Core released as the file starts
        for (int chunk = 0; chunk < 5; chunk++) begin
            page = page_for_chunk(chunk);
            repeat (2) begin
                rnd    = $random(seed);
                offset = rnd[13:0];
                data   = rnd[21:14];
                rom_byte({chunk[10:0], offset}, data);
                if (chunk < 4) begin
                    wait_flag("boot_wr", 1'b1);
                    expect_eq("boot_a.page", 32'(boot_a.pg.page), 32'(page));
                    expect_eq("boot_a.offset", 32'(boot_a.pg.offset), 32'(offset));
                    expect_eq("boot_dout", 32'(boot_dout), 32'(data));
                end
                repeat (3) begin            // Strobe lasts one cycle and chunk 4 gives none
                    @(negedge clk_48);
                    expect_eq("boot_wr", 32'(boot_wr), 0);
                end
            end
        end
        expect_eq("rom_loaded", 32'(rom_loaded), 0);   // Still loading
        @(posedge clk_48);
        ioctl_download <= 1'b0;
        wait_flag("rom_loaded", 1'b1);
        assert (rom_map === map_exp)
        else fail_run($sformatf("MISMATCH rom_map: got %h, expected %h", rom_map, map_exp));
        @(posedge clk_48);
        ioctl_index    <= 8'h04;            // Not a ROM file
        ioctl_download <= 1'b1;
        rom_byte({11'd1, 14'h0040}, 8'ha5);
        repeat (3) begin
            @(negedge clk_48);
            expect_eq("boot_wr", 32'(boot_wr), 0);
        end
        @(posedge clk_48);
        ioctl_download <= 1'b0;
    endtask

    task automatic test_nmi_trap();
        press_nmi();
        fetch_m1(16'h0066);                 // NMI vector fetch
        wait_flag("mf2_en", 1'b1);
        expect_eq("mf2_nmi", 32'(mf2_nmi), 0);
        check_window(16'h1234, 1'b1, 1'b0);
        check_window(16'h2abc, 1'b0, 1'b1);
        check_window(16'h4000, 1'b0, 1'b0);
    endtask

    task automatic test_shadow();
        logic [7:0] got;
        io_write(16'h7f00, 8'h05);          // Pen 5
        io_write(16'h7f00, 8'h4a);          // Its colour
        io_write(16'hbc00, 8'h0c);          // CRTC R12
        io_write(16'hbd00, 8'h30);
        io_write(16'h7f00, 8'h82);          // Mode 2
        mem_cycle(16'h2000 | {3'b000, 9'h1f9, 4'h5}, 1'b0, 8'h00, got);
        expect_eq("mf2_dout pen 5", 32'(got), 32'h4a);
        mem_cycle(16'h2000 | {3'b000, 9'h1db, 4'hc}, 1'b0, 8'h00, got);
        expect_eq("mf2_dout CRTC R12", 32'(got), 32'h30);
        mem_cycle(16'h2000 | 16'h1fef, 1'b0, 8'h00, got);
        expect_eq("mf2_dout mode", 32'(got), 32'h82);
    endtask

    task automatic test_ram();
        logic [7:0]  got;
        logic [7:0]  data;
        logic [15:0] addr;
        integer      rnd;
        rnd = 0;
        repeat (8) begin
            rnd  = $random(seed);
            addr = 16'h2000 | {3'b000, rnd[12:0]};
            data = rnd[20:13];
            mem_cycle(addr, 1'b1, data, got);
            mem_cycle(addr, 1'b0, 8'h00, got);
            expect_eq("mf2_dout", 32'(got), 32'(data));
        end
        mem_cycle(16'h4000 | {3'b000, rnd[12:0]}, 1'b0, 8'h00, got);   // Above the window
        expect_eq("mf2_dout outside window", 32'(got), 32'hff);
    endtask

    task automatic test_hide();
        logic [7:0] got;
        io_write(16'hfeea, 8'h00);
        wait_flag("mf2_en", 1'b0);
        mem_cycle(16'h2100, 1'b0, 8'h00, got);
        expect_eq("mf2_dout while disabled", 32'(got), 32'hff);
        io_write(16'hfee8, 8'h00);
        wait_flag("mf2_en", 1'b1);
        fetch_m1(16'h0065);                 // Hides the cartridge
        io_write(16'hfeea, 8'h00);
        wait_flag("mf2_en", 1'b0);
        io_write(16'hfee8, 8'h00);
        @(negedge clk_48);
        expect_eq("mf2_en while hidden", 32'(mf2_en), 0);
        press_nmi();
        fetch_m1(16'h0066);
        wait_flag("mf2_en", 1'b1);
        expect_eq("mf2_nmi", 32'(mf2_nmi), 0);
        io_write(16'hfeea, 8'h00);
        wait_flag("mf2_en", 1'b0);
        io_write(16'hfee8, 8'h00);
        wait_flag("mf2_en", 1'b1);          // Port answers again once unhidden
    endtask

    initial begin
        seed = 39;
        ioctl_download <= 1'b0;
        ioctl_wr       <= 1'b0;
        ioctl_addr     <= '0;
        ioctl_dout     <= '0;
        ioctl_index    <= '0;
        cpu_addr       <= '0;
        cpu_dout       <= '0;
        m1             <= 1'b0;
        iorq           <= 1'b0;
        wr             <= 1'b0;
        mem_rd         <= 1'b0;
        mem_wr         <= 1'b0;
        key_nmi        <= 1'b0;
        wait (RESET === 1'b0);
        @(negedge clk_48);
        expect_eq("core_reset", 32'(core_reset), 1);
        expect_eq("rom_loaded", 32'(rom_loaded), 0);
        expect_eq("mf2_en", 32'(mf2_en), 0);
        test_rom_load();
        test_nmi_trap();
        test_shadow();
        test_ram();
        test_hide();
        $display("Done: no errors");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run($sformatf("Timed out after %0d ns before the tests finished", WATCHDOG_NS));
    end

endmodule

/* flist.f */
+incdir+include
design/cpc_pkg.sv
design/rom_loader.sv
design/mf2_trap.sv
design/mf2_shadow.sv
design/cpc_mf2_top.sv
tests/tb_clock.sv
tests/tb_top.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_top -f flist.f

# The simulator exits non-zero on $fatal, so keep its output and judge by the text
out=$(./obj_dir/Vtb_top 2>&1) || true
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx 'Done: no errors'
echo "Simulation passed"
